// ==== Bender.yml ====
package:
  name: core_exec

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/core_pkg.sv
      - rtl/core_alu.sv
      - rtl/core_branch.sv
      - rtl/core_exec_result.sv
      - rtl/core_exec.sv
      - target: test
        files:
          - tests/core_exec_tb.sv

// ==== project.f ====
+incdir+rtl
rtl/core_pkg.sv
rtl/core_alu.sv
rtl/core_branch.sv
rtl/core_exec_result.sv
rtl/core_exec.sv
tests/core_exec_tb.sv

// ==== rtl/core_alu.sv ====
/* Combinational ALU of the execute stage. Undefined opcodes give zero.
   Shifts use only the low CORE_SHAMT_W bits of src2. */

`timescale 1ns/1ps

`include "core_defines.svh"

module core_alu (
	input  logic [`CORE_XLEN-1:0] src1,
	input  logic [`CORE_XLEN-1:0] src2,
	input  core_pkg::alu_op_e     alu_op,
	output logic [`CORE_XLEN-1:0] alu_result
);

	// shift amount from the low bits of src2
	logic [`CORE_SHAMT_W-1:0] shamt;

	// sign-extended sum for the average
	logic [`CORE_XLEN:0] am_sum;

	// compare flags
	logic lt_s;
	logic lt_u;

	// upper bits of src2 are junk for shifts
	assign shamt = src2[`CORE_SHAMT_W-1:0];

	// widen by one bit so the carry survives
	assign am_sum = {src1[`CORE_XLEN-1], src1} + {src2[`CORE_XLEN-1], src2};

	assign lt_s = $signed(src1) < $signed(src2);
	assign lt_u = src1 < src2;

	// ----------------------------------------------------------------------
	// operation select
	// ----------------------------------------------------------------------
	always_comb begin
		case (alu_op)
			// add and sub wrap modulo 2^XLEN
			core_pkg::ALU_ADD: alu_result = src1 + src2;
			core_pkg::ALU_SUB: alu_result = src1 - src2;
			// bitwise logic
			core_pkg::ALU_AND: alu_result = src1 & src2;
			core_pkg::ALU_OR:  alu_result = src1 | src2;
			core_pkg::ALU_XOR: alu_result = src1 ^ src2;
			// compares give 1 or 0
			core_pkg::ALU_SLT: begin
				alu_result = {{(`CORE_XLEN-1){1'b0}}, lt_s};
			end
			core_pkg::ALU_SLTU: begin
				alu_result = {{(`CORE_XLEN-1){1'b0}}, lt_u};
			end
			// logical shifts fill with zero
			core_pkg::ALU_SLL: alu_result = src1 << shamt;
			core_pkg::ALU_SRL: alu_result = src1 >> shamt;
			// sign fill
			core_pkg::ALU_SRA: begin
				alu_result = $unsigned($signed(src1) >>> shamt);
			end
			// dropping bit 0 of the wide sum is the arithmetic shift by one
			core_pkg::ALU_AM: alu_result = am_sum[`CORE_XLEN:1];
			default: alu_result = '0;
		endcase
	end

endmodule

// ==== rtl/core_branch.sv ====
/* Combinational branch unit with its own comparator. The target is pc+imm
   for any real condition and zero for BR_NONE. */

`timescale 1ns/1ps

`include "core_defines.svh"

module core_branch (
	input  logic [`CORE_XLEN-1:0] src1,
	input  logic [`CORE_XLEN-1:0] src2,
	input  logic [`CORE_XLEN-1:0] pc,
	input  logic [`CORE_XLEN-1:0] imm,
	input  core_pkg::brnch_cnd_e  brnch_cnd,
	output logic                  brnch_taken,
	output logic [`CORE_XLEN-1:0] brnch_target
);

	// compare results
	logic eq;
	logic lt_s;
	logic lt_u;

	// raw target sum
	logic [`CORE_XLEN-1:0] target_sum;

	// ----------------------------------------------------------------------
	// comparator
	// ----------------------------------------------------------------------
	assign eq   = src1 == src2;
	assign lt_s = $signed(src1) < $signed(src2);
	assign lt_u = src1 < src2;

	// condition select
	always_comb begin
		case (brnch_cnd)
			core_pkg::BR_EQ:  brnch_taken = eq;
			core_pkg::BR_NE:  brnch_taken = !eq;
			core_pkg::BR_LT:  brnch_taken = lt_s;
			// ge is the inverse of lt
			core_pkg::BR_GE:  brnch_taken = !lt_s;
			core_pkg::BR_LTU: brnch_taken = lt_u;
			core_pkg::BR_GEU: brnch_taken = !lt_u;
			// BR_NONE and undefined encodings never branch
			default:          brnch_taken = 1'b0;
		endcase
	end

	// ----------------------------------------------------------------------
	// target adder
	// ----------------------------------------------------------------------
	assign target_sum = pc + imm;

	// zero keeps the field clean for non-branches
	assign brnch_target = (brnch_cnd == core_pkg::BR_NONE) ? '0 : target_sum;

endmodule

// ==== rtl/core_defines.svh ====
/* Widths shared by the execute stage. Only 32-bit data is supported.
   The shift amount width must stay log2 of the data width. */

`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// ----------------------------------------------------------------------
// datapath widths
// ----------------------------------------------------------------------

// data and address width
`define CORE_XLEN 32

// shift amount width
// taken from the low bits of src2
`define CORE_SHAMT_W 5

`endif

// ==== rtl/core_exec.sv ====
/* Execute stage top. ALU and branch unit see the same operands in parallel.
   One registered cycle of latency, one operation per cycle throughput. */

`timescale 1ns/1ps

`include "core_defines.svh"

module core_exec (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  in_valid,
	output logic                  in_ready,
	input  logic [`CORE_XLEN-1:0] src1,
	input  logic [`CORE_XLEN-1:0] src2,
	input  core_pkg::alu_op_e     alu_op,
	input  core_pkg::brnch_cnd_e  brnch_cnd,
	input  logic [`CORE_XLEN-1:0] pc,
	input  logic [`CORE_XLEN-1:0] imm,
	output logic                  out_valid,
	input  logic                  out_ready,
	output logic [`CORE_XLEN-1:0] result,
	output logic                  taken,
	output logic [`CORE_XLEN-1:0] target
);

	// combinational results into the register stage
	logic [`CORE_XLEN-1:0] alu_result;
	logic                  brnch_taken;
	logic [`CORE_XLEN-1:0] brnch_target;

	// ----------------------------------------------------------------------
	// parallel datapath
	// ----------------------------------------------------------------------
	core_alu i_core_alu (
		.src1       (src1),
		.src2       (src2),
		.alu_op     (alu_op),
		.alu_result (alu_result)
	);

	// own comparator, no path through the alu
	core_branch i_core_branch (
		.src1         (src1),
		.src2         (src2),
		.pc           (pc),
		.imm          (imm),
		.brnch_cnd    (brnch_cnd),
		.brnch_taken  (brnch_taken),
		.brnch_target (brnch_target)
	);

	// ----------------------------------------------------------------------
	// result register
	// ----------------------------------------------------------------------
	core_exec_result i_core_exec_result (
		.clk          (clk),
		.rst_n        (rst_n),
		.in_valid     (in_valid),
		.in_ready     (in_ready),
		.alu_result   (alu_result),
		.brnch_taken  (brnch_taken),
		.brnch_target (brnch_target),
		.out_valid    (out_valid),
		.out_ready    (out_ready),
		.result       (result),
		.taken        (taken),
		.target       (target)
	);

endmodule

// ==== rtl/core_exec_result.sv ====
/* One-entry output register of the execute stage with valid/ready on both
   sides. Accepts a new beat on the same edge that the held one leaves. */

`timescale 1ns/1ps

`include "core_defines.svh"

module core_exec_result (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  in_valid,
	output logic                  in_ready,
	input  logic [`CORE_XLEN-1:0] alu_result,
	input  logic                  brnch_taken,
	input  logic [`CORE_XLEN-1:0] brnch_target,
	output logic                  out_valid,
	input  logic                  out_ready,
	output logic [`CORE_XLEN-1:0] result,
	output logic                  taken,
	output logic [`CORE_XLEN-1:0] target
);

	// input transfer strobe
	logic in_fire;

	// free when empty or draining this cycle
	assign in_ready = !out_valid || out_ready;
	assign in_fire  = in_valid && in_ready;

	// ----------------------------------------------------------------------
	// valid and taken flags
	// ----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
			taken     <= 1'b0;
		end else if (in_ready) begin
			// empty slot or beat leaving, so load whatever arrives
			out_valid <= in_valid;
			// qualified by in_valid so an idle slot never flags a branch
			taken     <= in_valid && brnch_taken;
		end
	end

	// payload
	always_ff @(posedge clk) begin
		if (in_fire) begin
			result <= alu_result;
			target <= brnch_target;
		end
	end

	// ----------------------------------------------------------------------
	// assertions
	// ----------------------------------------------------------------------

	// stalled beat holds all fields
	property p_hold_stable;
		@(posedge clk) disable iff (!rst_n)
		(out_valid && !out_ready) |=>
			(out_valid && $stable(result) && $stable(taken) && $stable(target));
	endproperty
	a_hold_stable: assert property (p_hold_stable)
		else $error("output beat changed while stalled");

	// reset empties the stage
	property p_reset_empty;
		@(posedge clk) !rst_n |=> !out_valid;
	endproperty
	a_reset_empty: assert property (p_reset_empty)
		else $error("out_valid high in the cycle after reset");

	// no branch flag on an empty slot
	property p_taken_valid;
		@(posedge clk) disable iff (!rst_n)
		!out_valid |-> !taken;
	endproperty
	a_taken_valid: assert property (p_taken_valid)
		else $error("taken high while out_valid low");

endmodule

// ==== rtl/core_pkg.sv ====
/* Opcode and branch condition types of the execute stage.
   Encodings not listed here are treated as undefined by the datapath. */

package core_pkg;

	// ----------------------------------------------------------------------
	// alu operations
	// ----------------------------------------------------------------------
	typedef enum logic [3:0] {
		ALU_ADD  = 4'd0,
		ALU_SUB  = 4'd1,
		ALU_AND  = 4'd2,
		ALU_OR   = 4'd3,
		ALU_XOR  = 4'd4,
		// signed set less than
		ALU_SLT  = 4'd5,
		ALU_SLTU = 4'd6,
		ALU_SLL  = 4'd7,
		ALU_SRL  = 4'd8,
		// arithmetic right shift with sign fill
		ALU_SRA  = 4'd9,
		// average of both operands
		ALU_AM   = 4'd10
	} alu_op_e;

	// ----------------------------------------------------------------------
	// branch conditions
	// ----------------------------------------------------------------------
	typedef enum logic [2:0] {
		// not a branch
		BR_NONE = 3'd0,
		BR_EQ   = 3'd1,
		BR_NE   = 3'd2,
		BR_LT   = 3'd3,
		BR_GE   = 3'd4,
		BR_LTU  = 3'd5,
		BR_GEU  = 3'd6
	} brnch_cnd_e;

endpackage

// ==== tests/core_exec_tb.sv ====
/* Testbench for the execute stage. Random operations from a fixed seed,
   random back-pressure on the output, in-order scoreboard. */

`timescale 1ns/1ps

`include "core_defines.svh"

module core_exec_tb;

	localparam int NUM_OPS     = 2000;
	localparam int WAIT_CYCLES = 200;

	// expected beat with op and condition for messages
	typedef struct packed {
		core_pkg::alu_op_e     op;
		core_pkg::brnch_cnd_e  cnd;
		logic [`CORE_XLEN-1:0] result;
		logic                  taken;
		logic [`CORE_XLEN-1:0] target;
	} beat_t;

	logic                  clk;
	logic                  rst_n;
	logic                  in_valid;
	logic                  in_ready;
	logic [`CORE_XLEN-1:0] src1;
	logic [`CORE_XLEN-1:0] src2;
	core_pkg::alu_op_e     alu_op;
	core_pkg::brnch_cnd_e  brnch_cnd;
	logic [`CORE_XLEN-1:0] pc;
	logic [`CORE_XLEN-1:0] imm;
	logic                  out_valid;
	logic                  out_ready;
	logic [`CORE_XLEN-1:0] result;
	logic                  taken;
	logic [`CORE_XLEN-1:0] target;

	// scoreboard and counters
	beat_t exp_q[$];
	int    mismatches;
	int    failures;
	int    checked;
	bit    timed_out;

	core_exec i_core_exec (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.src1      (src1),
		.src2      (src2),
		.alu_op    (alu_op),
		.brnch_cnd (brnch_cnd),
		.pc        (pc),
		.imm       (imm),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.result    (result),
		.taken     (taken),
		.target    (target)
	);

	// 40 ns period
	always #20 clk = ~clk;

	// ----------------------------------------------------------------------
	// reference model
	// ----------------------------------------------------------------------

	// signed less-than from the sign bits or an unsigned compare when they agree
	function automatic logic less_signed(input logic [`CORE_XLEN-1:0] a,
		input logic [`CORE_XLEN-1:0] b);
		if (a[`CORE_XLEN-1] != b[`CORE_XLEN-1])
			return a[`CORE_XLEN-1];
		return a < b;
	endfunction

	function automatic beat_t core_exec_model(input core_pkg::alu_op_e op,
		input core_pkg::brnch_cnd_e cnd, input logic [`CORE_XLEN-1:0] a,
		input logic [`CORE_XLEN-1:0] b, input logic [`CORE_XLEN-1:0] pc_v,
		input logic [`CORE_XLEN-1:0] imm_v);
		beat_t                    beat;
		logic [`CORE_SHAMT_W-1:0] sh;
		longint                   sum;
		longint                   avg;
		logic                     lt_s;
		logic                     lt_u;
		sh   = b[`CORE_SHAMT_W-1:0];
		sum  = longint'($signed(a)) + longint'($signed(b));
		avg  = sum >>> 1;
		lt_s = less_signed(a, b);
		lt_u = a < b;
		beat.op  = op;
		beat.cnd = cnd;
		case (op)
			core_pkg::ALU_ADD:  beat.result = a + b;
			core_pkg::ALU_SUB:  beat.result = a - b;
			core_pkg::ALU_AND:  beat.result = a & b;
			core_pkg::ALU_OR:   beat.result = a | b;
			core_pkg::ALU_XOR:  beat.result = a ^ b;
			core_pkg::ALU_SLT:  beat.result = lt_s ? 1 : 0;
			core_pkg::ALU_SLTU: beat.result = lt_u ? 1 : 0;
			core_pkg::ALU_SLL:  beat.result = a << sh;
			core_pkg::ALU_SRL:  beat.result = a >> sh;
			// logical shift and then fill the vacated top bits with the sign
			core_pkg::ALU_SRA: begin
				beat.result = (a >> sh) |
					(a[`CORE_XLEN-1] ? ~({`CORE_XLEN{1'b1}} >> sh) : '0);
			end
			core_pkg::ALU_AM:   beat.result = avg[`CORE_XLEN-1:0];
			default:            beat.result = '0;
		endcase
		case (cnd)
			core_pkg::BR_EQ:  beat.taken = (a == b);
			core_pkg::BR_NE:  beat.taken = (a != b);
			core_pkg::BR_LT:  beat.taken = lt_s;
			core_pkg::BR_GE:  beat.taken = !lt_s;
			core_pkg::BR_LTU: beat.taken = lt_u;
			core_pkg::BR_GEU: beat.taken = !lt_u;
			default:          beat.taken = 1'b0;
		endcase
		beat.target = (cnd == core_pkg::BR_NONE) ? '0 : pc_v + imm_v;
		return beat;
	endfunction

	// edge values a quarter of the time
	function automatic logic [`CORE_XLEN-1:0] pick_operand();
		case ($urandom_range(11))
			0:       return '0;
			1:       return '1;
			2:       return {1'b1, {(`CORE_XLEN-1){1'b0}}};
			default: return $urandom();
		endcase
	endfunction

	// ----------------------------------------------------------------------
	// back-pressure and scoreboard
	// ----------------------------------------------------------------------

	// ready about 70 percent of cycles
	always @(posedge clk) begin
		out_ready <= ($urandom_range(99) < 70);
	end

	always @(posedge clk) begin
		beat_t want;
		string name;
		if (rst_n && out_valid && out_ready) begin
			assert (exp_q.size() != 0) else begin
				$display("output beat arrived with no operation pending");
				failures++;
			end
			if (exp_q.size() != 0) begin
				want = exp_q.pop_front();
				name = $sformatf("%s/%s", want.op.name(), want.cnd.name());
				checked++;
				assert (result === want.result) else begin
					$display("Mismatch %s result: expected %h, actual %h",
						name, want.result, result);
					mismatches++;
				end
				assert (taken === want.taken) else begin
					$display("Mismatch %s taken: expected %b, actual %b",
						name, want.taken, taken);
					mismatches++;
				end
				assert (target === want.target) else begin
					$display("Mismatch %s target: expected %h, actual %h",
						name, want.target, target);
					mismatches++;
				end
			end
		end
	end

	// ----------------------------------------------------------------------
	// main sequence
	// ----------------------------------------------------------------------
	initial begin
		int                    waited;
		logic [`CORE_XLEN-1:0] a;
		logic [`CORE_XLEN-1:0] b;
		logic [`CORE_XLEN-1:0] p;
		logic [`CORE_XLEN-1:0] i;
		core_pkg::alu_op_e     op;
		core_pkg::brnch_cnd_e  cnd;
		void'($urandom(32'hff4c));
		clk        = 1'b0;
		rst_n      = 1'b0;
		in_valid   = 1'b0;
		src1       = '0;
		src2       = '0;
		alu_op     = core_pkg::ALU_ADD;
		brnch_cnd  = core_pkg::BR_NONE;
		pc         = '0;
		imm        = '0;
		out_ready  = 1'b0;
		mismatches = 0;
		failures   = 0;
		checked    = 0;
		timed_out  = 1'b0;
		repeat (10) @(posedge clk);
		rst_n <= 1'b1;

		// idle state before any input
		@(negedge clk);
		assert (!out_valid) else begin
			$display("out_valid is high right after reset");
			failures++;
		end
		assert (in_ready) else begin
			$display("in_ready is low right after reset");
			failures++;
		end

		@(posedge clk);
		for (int n = 0; n < NUM_OPS && !timed_out; n++) begin
			// occasional gap in the input stream
			if ($urandom_range(9) == 0) begin
				in_valid <= 1'b0;
				@(posedge clk);
			end
			a   = pick_operand();
			b   = pick_operand();
			p   = $urandom();
			i   = $urandom();
			op  = core_pkg::alu_op_e'($urandom_range(10));
			cnd = core_pkg::brnch_cnd_e'($urandom_range(6));
			in_valid  <= 1'b1;
			src1      <= a;
			src2      <= b;
			pc        <= p;
			imm       <= i;
			alu_op    <= op;
			brnch_cnd <= cnd;
			// transfer on the first edge with in_ready high
			waited = 0;
			do begin
				@(posedge clk);
				waited++;
			end while (!in_ready && waited < WAIT_CYCLES);
			if (!in_ready) begin
				$display("timeout: in_ready stayed low for %0d cycles", WAIT_CYCLES);
				failures++;
				timed_out = 1'b1;
			end else begin
				exp_q.push_back(core_exec_model(op, cnd, a, b, p, i));
			end
		end
		in_valid <= 1'b0;

		// let the last beats drain
		waited = 0;
		while (!timed_out && exp_q.size() != 0 && waited < WAIT_CYCLES) begin
			@(negedge clk);
			waited++;
		end
		if (!timed_out && exp_q.size() != 0) begin
			$display("timeout: %0d operations never left the output", exp_q.size());
			failures++;
		end

		// the last beat leaves once and no copy of it stays behind
		assert (timed_out || exp_q.size() != 0 || !out_valid) else begin
			$display("out_valid still high after the last operation left");
			failures++;
		end

		$display("errors: %0d mismatches, %0d other failures, %0d operations checked",
			mismatches, failures, checked);
		if (mismatches == 0 && failures == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule
